//--- common/exec_pkg.sv
/*
 * Execute unit shared definitions
 * data widths, opcode and result-class encodings,
 * and the payload structs passed between pipeline stages
 */

package exec_pkg;

    localparam int DATA_W     = 32;
    localparam int DWORD_W    = 2 * DATA_W;  // full product width
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;           // low bits of operand a used as shift amount
    localparam int OP_W       = 5;
    localparam int RES_W      = 3;
    localparam int LCNT_W     = 6;           // leading count spans 0..32

    typedef enum logic [OP_W-1:0] {
        OP_OR,
        OP_AND,
        OP_NOR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADD,   // signed, write suppressed on overflow
        OP_ADDU,
        OP_SUB,   // signed, write suppressed on overflow
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_CLZ,
        OP_CLO,
        OP_MUL,   // low product word to rd
        OP_MULT,  // product to hi/lo
        OP_MULTU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } alu_op_e;

    typedef enum logic [RES_W-1:0] {
        RES_LOGIC,
        RES_SHIFT,
        RES_ARITH,
        RES_MUL,
        RES_MOVE,
        RES_NONE
    } res_sel_e;

    typedef struct packed {
        alu_op_e                op;
        logic [DATA_W-1:0]      op_a;
        logic [DATA_W-1:0]      op_b;
        logic [REG_ADDR_W-1:0]  rd;
        logic                   wreg;
    } exec_req_t;

    typedef struct packed {
        exec_req_t              req;
        res_sel_e               res_sel;
        logic                   sub;         // b is negated before the add
        logic                   mul_signed;
        logic                   ovf_chk;     // add/sub trap on overflow
        logic                   hilo_we;
    } decoded_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0]  rd;
        logic                   wreg;
        res_sel_e               res_sel;
        alu_op_e                op;
        logic [DATA_W-1:0]      alu_res;
        logic                   overflow;    // already qualified by ovf_chk
        logic [DWORD_W-1:0]     product;
        logic [DATA_W-1:0]      op_a;        // source for mthi/mtlo
        logic                   hilo_we;
    } computed_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0]  rd;
        logic                   wreg;
        logic [DATA_W-1:0]      wdata;
    } exec_rsp_t;

endpackage

//--- alu/exec_alu.sv
/*
 * Execute ALU
 * combinational logic ops, shifts, add/sub with signed overflow,
 * set-less-than compares and leading zero/one count
 */

`timescale 1ns/1ps

module exec_alu (
    input  exec_pkg::alu_op_e             op_i,
    input  logic                          sub_i,
    input  logic [exec_pkg::DATA_W-1:0]   a_i,
    input  logic [exec_pkg::DATA_W-1:0]   b_i,
    output logic [exec_pkg::DATA_W-1:0]   result_o,
    output logic                          overflow_o
);

    localparam int MSB = exec_pkg::DATA_W - 1;

    logic [exec_pkg::SHAMT_W-1:0] shamt;
    logic [exec_pkg::DATA_W-1:0]  b_eff;
    logic [exec_pkg::DATA_W-1:0]  sum;
    logic                         slt_res;
    logic                         sltu_res;
    logic [exec_pkg::DATA_W-1:0]  lc_src;
    logic [exec_pkg::LCNT_W-1:0]  lead_cnt;

    assign shamt = a_i[exec_pkg::SHAMT_W-1:0];  // shift amount from a

    // subtract as a + ~b + 1
    assign b_eff = sub_i ? ~b_i : b_i;
    assign sum   = a_i + b_eff + {{MSB{1'b0}}, sub_i};

    // same-sign inputs giving a different-sign sum
    assign overflow_o = (a_i[MSB] == b_eff[MSB]) && (sum[MSB] != a_i[MSB]);

    assign slt_res = (a_i[MSB] && !b_i[MSB]) ||            // neg < pos
                     ((a_i[MSB] == b_i[MSB]) && sum[MSB]);  // same sign, negative diff
    assign sltu_res = a_i < b_i;

    // clo is clz of the inverted operand
    assign lc_src = (op_i == exec_pkg::OP_CLO) ? ~a_i : a_i;

    always_comb begin
        lead_cnt = exec_pkg::LCNT_W'(exec_pkg::DATA_W);  // no bit set
        for (int i = 0; i < exec_pkg::DATA_W; i++) begin
            if (lc_src[i]) begin
                lead_cnt = exec_pkg::LCNT_W'(MSB - i);  // highest set bit wins
            end
        end
    end

    always_comb begin
        case (op_i)
            exec_pkg::OP_OR: begin
                result_o = a_i | b_i;
            end
            exec_pkg::OP_AND: begin
                result_o = a_i & b_i;
            end
            exec_pkg::OP_NOR: begin
                result_o = ~(a_i | b_i);
            end
            exec_pkg::OP_XOR: begin
                result_o = a_i ^ b_i;
            end
            exec_pkg::OP_SLL: begin
                result_o = b_i << shamt;
            end
            exec_pkg::OP_SRL: begin
                result_o = b_i >> shamt;
            end
            exec_pkg::OP_SRA: begin
                result_o = $unsigned($signed(b_i) >>> shamt);  // sign fill
            end
            exec_pkg::OP_ADD, exec_pkg::OP_ADDU,
            exec_pkg::OP_SUB, exec_pkg::OP_SUBU: begin
                result_o = sum;
            end
            exec_pkg::OP_SLT: begin
                result_o = {{MSB{1'b0}}, slt_res};
            end
            exec_pkg::OP_SLTU: begin
                result_o = {{MSB{1'b0}}, sltu_res};
            end
            exec_pkg::OP_CLZ, exec_pkg::OP_CLO: begin
                result_o = {{(exec_pkg::DATA_W - exec_pkg::LCNT_W){1'b0}}, lead_cnt};
            end
            default: begin
                result_o = '0;  // mul and hi/lo ops take other paths
            end
        endcase
    end

endmodule

//--- mult/exec_multiplier.sv
/*
 * Execute multiplier
 * 32x32 to 64-bit product, signed via magnitude multiply
 * followed by a sign correction
 */

`timescale 1ns/1ps

module exec_multiplier (
    input  logic                          signed_i,
    input  logic [exec_pkg::DATA_W-1:0]   a_i,
    input  logic [exec_pkg::DATA_W-1:0]   b_i,
    output logic [exec_pkg::DWORD_W-1:0]  product_o
);

    localparam int MSB = exec_pkg::DATA_W - 1;

    logic [exec_pkg::DATA_W-1:0]  mag_a;
    logic [exec_pkg::DATA_W-1:0]  mag_b;
    logic [exec_pkg::DWORD_W-1:0] mag_prod;
    logic                         neg;

    // magnitudes only differ from the inputs for signed negatives
    assign mag_a = (signed_i && a_i[MSB]) ? (~a_i + 1'b1) : a_i;
    assign mag_b = (signed_i && b_i[MSB]) ? (~b_i + 1'b1) : b_i;

    assign mag_prod = {{exec_pkg::DATA_W{1'b0}}, mag_a} *
                      {{exec_pkg::DATA_W{1'b0}}, mag_b};

    assign neg = signed_i && (a_i[MSB] ^ b_i[MSB]);  // signs differ

    assign product_o = neg ? (~mag_prod + 1'b1) : mag_prod;

endmodule

//--- design/operand_stage.sv
/*
 * Operand stage
 * decodes the opcode into a result class and control flags
 * and registers the instruction for the compute stage
 */

`timescale 1ns/1ps

module operand_stage (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 in_valid_i,
    input  exec_pkg::exec_req_t  in_i,
    output logic                 in_ready_o,
    output logic                 out_valid_o,
    output exec_pkg::decoded_t   out_o,
    input  logic                 out_ready_i
);

    exec_pkg::decoded_t dec;
    exec_pkg::decoded_t data_q;
    logic               valid_q;

    always_comb begin
        dec            = '0;
        dec.req        = in_i;
        dec.sub        = in_i.op inside {exec_pkg::OP_SUB, exec_pkg::OP_SUBU, exec_pkg::OP_SLT};
        dec.mul_signed = in_i.op inside {exec_pkg::OP_MUL, exec_pkg::OP_MULT};
        dec.ovf_chk    = in_i.op inside {exec_pkg::OP_ADD, exec_pkg::OP_SUB};
        dec.hilo_we    = in_i.op inside {exec_pkg::OP_MULT, exec_pkg::OP_MULTU,
                                         exec_pkg::OP_MTHI, exec_pkg::OP_MTLO};
        case (in_i.op)
            exec_pkg::OP_OR, exec_pkg::OP_AND,
            exec_pkg::OP_NOR, exec_pkg::OP_XOR:  dec.res_sel = exec_pkg::RES_LOGIC;
            exec_pkg::OP_SLL, exec_pkg::OP_SRL,
            exec_pkg::OP_SRA:                    dec.res_sel = exec_pkg::RES_SHIFT;
            exec_pkg::OP_MUL:                    dec.res_sel = exec_pkg::RES_MUL;
            exec_pkg::OP_MFHI, exec_pkg::OP_MFLO: dec.res_sel = exec_pkg::RES_MOVE;
            exec_pkg::OP_MULT, exec_pkg::OP_MULTU,
            exec_pkg::OP_MTHI, exec_pkg::OP_MTLO: dec.res_sel = exec_pkg::RES_NONE;
            default:                             dec.res_sel = exec_pkg::RES_ARITH;
        endcase
    end

    assign in_ready_o = !valid_q || out_ready_i;  // empty or draining

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_ready_o && in_valid_i) begin
            data_q <= dec;
        end
    end

    assign out_valid_o = valid_q;
    assign out_o       = data_q;

endmodule

//--- design/compute_stage.sv
/*
 * Compute stage
 * runs the ALU and multiplier side by side on the registered
 * operands and registers both results with the routing fields
 */

`timescale 1ns/1ps

module compute_stage (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 in_valid_i,
    input  exec_pkg::decoded_t   in_i,
    output logic                 in_ready_o,
    output logic                 out_valid_o,
    output exec_pkg::computed_t  out_o,
    input  logic                 out_ready_i
);

    logic [exec_pkg::DATA_W-1:0]  alu_res;
    logic                         alu_ovf;
    logic [exec_pkg::DWORD_W-1:0] product;
    exec_pkg::computed_t          res_d;
    exec_pkg::computed_t          data_q;
    logic                         valid_q;

    exec_alu exec_alu_i (
        .op_i       (in_i.req.op),
        .sub_i      (in_i.sub),
        .a_i        (in_i.req.op_a),
        .b_i        (in_i.req.op_b),
        .result_o   (alu_res),
        .overflow_o (alu_ovf)
    );

    exec_multiplier exec_multiplier_i (
        .signed_i  (in_i.mul_signed),
        .a_i       (in_i.req.op_a),
        .b_i       (in_i.req.op_b),
        .product_o (product)
    );

    always_comb begin
        res_d.rd       = in_i.req.rd;
        res_d.wreg     = in_i.req.wreg;
        res_d.res_sel  = in_i.res_sel;
        res_d.op       = in_i.req.op;
        res_d.alu_res  = alu_res;
        res_d.overflow = alu_ovf && in_i.ovf_chk;  // only add/sub care
        res_d.product  = product;
        res_d.op_a     = in_i.req.op_a;
        res_d.hilo_we  = in_i.hilo_we;
    end

    assign in_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_ready_o && in_valid_i) begin
            data_q <= res_d;
        end
    end

    assign out_valid_o = valid_q;
    assign out_o       = data_q;

endmodule

//--- design/writeback_stage.sv
/*
 * Writeback stage
 * selects the final result by class, suppresses the write on
 * checked overflow, and owns the HI/LO pair for mult and moves
 */

`timescale 1ns/1ps

module writeback_stage (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 in_valid_i,
    input  exec_pkg::computed_t  in_i,
    output logic                 in_ready_o,
    output logic                 rsp_valid_o,
    output exec_pkg::exec_rsp_t  rsp_o,
    input  logic                 rsp_ready_i
);

    logic [exec_pkg::DATA_W-1:0] hi_q;
    logic [exec_pkg::DATA_W-1:0] lo_q;
    logic [exec_pkg::DATA_W-1:0] wdata;
    logic                        accept;
    exec_pkg::exec_rsp_t         rsp_d;
    exec_pkg::exec_rsp_t         rsp_q;
    logic                        valid_q;

    assign in_ready_o = !valid_q || rsp_ready_i;
    assign accept     = in_valid_i && in_ready_o;

    always_comb begin
        case (in_i.res_sel)
            exec_pkg::RES_LOGIC, exec_pkg::RES_SHIFT,
            exec_pkg::RES_ARITH: begin
                wdata = in_i.alu_res;
            end
            exec_pkg::RES_MUL: begin
                wdata = in_i.product[exec_pkg::DATA_W-1:0];  // low word
            end
            exec_pkg::RES_MOVE: begin
                wdata = (in_i.op == exec_pkg::OP_MFHI) ? hi_q : lo_q;  // older writes visible
            end
            default: begin
                wdata = '0;
            end
        endcase
    end

    always_comb begin
        rsp_d.rd    = in_i.rd;
        rsp_d.wreg  = in_i.wreg && !in_i.overflow;  // trap drops the write
        rsp_d.wdata = wdata;
    end

    // hi/lo change only as an item is taken, so order is kept
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (accept && in_i.hilo_we) begin
            case (in_i.op)
                exec_pkg::OP_MULT, exec_pkg::OP_MULTU: begin
                    hi_q <= in_i.product[exec_pkg::DWORD_W-1:exec_pkg::DATA_W];
                    lo_q <= in_i.product[exec_pkg::DATA_W-1:0];
                end
                exec_pkg::OP_MTHI: begin
                    hi_q <= in_i.op_a;
                end
                exec_pkg::OP_MTLO: begin
                    lo_q <= in_i.op_a;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_valid_o = valid_q;
    assign rsp_o       = rsp_q;

endmodule

//--- design/exec_unit_top.sv
/*
 * Execute unit top level
 * three-stage valid/ready pipeline: decode, compute, writeback
 */

`timescale 1ns/1ps

module exec_unit_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_valid_i,
    input  exec_pkg::exec_req_t  req_i,
    output logic                 req_ready_o,
    output logic                 rsp_valid_o,
    output exec_pkg::exec_rsp_t  rsp_o,
    input  logic                 rsp_ready_i
);

    logic                  s1_valid;
    logic                  s1_ready;
    exec_pkg::decoded_t    s1_data;
    logic                  s2_valid;
    logic                  s2_ready;
    exec_pkg::computed_t   s2_data;

    operand_stage operand_stage_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (req_valid_i),
        .in_i        (req_i),
        .in_ready_o  (req_ready_o),
        .out_valid_o (s1_valid),
        .out_o       (s1_data),
        .out_ready_i (s1_ready)
    );

    compute_stage compute_stage_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (s1_valid),
        .in_i        (s1_data),
        .in_ready_o  (s1_ready),
        .out_valid_o (s2_valid),
        .out_o       (s2_data),
        .out_ready_i (s2_ready)
    );

    writeback_stage writeback_stage_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (s2_valid),
        .in_i        (s2_data),
        .in_ready_o  (s2_ready),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .rsp_ready_i (rsp_ready_i)
    );

endmodule

//--- sim/exec_unit_tb.sv
/*
 * Execute unit testbench
 * directed and random instructions through the three-stage pipeline,
 * checked against a reference model that tracks HI/LO, with back-pressure
 */

`timescale 1ns/1ps

module exec_unit_tb;

    localparam int     NUM_TXN        = 2000;
    localparam int     STEADY_TXN     = 200;    // latency checked without back-pressure
    localparam int     LATENCY        = 3;      // acceptance edge to transfer edge
    localparam int     RESET_CYCLES   = 16;
    localparam int     TIMEOUT_CYCLES = 4 * NUM_TXN + 200;
    localparam longint INT_MAX        = 2147483647;
    localparam longint INT_MIN        = -INT_MAX - 1;

    logic                clk_i;
    logic                rst_n_i;
    logic                req_valid_i;
    exec_pkg::exec_req_t req_i;
    logic                req_ready_o;
    logic                rsp_valid_o;
    exec_pkg::exec_rsp_t rsp_o;
    logic                rsp_ready_i;

    integer              seed = 11508;
    int                  cycle = 0;
    int                  n_issued = 0;
    int                  n_checked = 0;
    logic [31:0]         hi_model = '0;
    logic [31:0]         lo_model = '0;
    exec_pkg::exec_rsp_t exp_q[$];
    int                  acc_q[$];      // acceptance cycle or -1 when not timed
    exec_pkg::exec_req_t directed_q[$];
    logic                held_valid = 1'b0;
    exec_pkg::exec_rsp_t held_rsp;
    exec_pkg::exec_rsp_t exp_rsp;
    int                  acc_cycle;

    exec_unit_top exec_unit_top_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .rsp_ready_i (rsp_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        fail_run($sformatf("** Error at %0t: %s expected 0x%0h, got 0x%0h",
                           $time, name, exp, got));
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic int leading_zeros(input logic [31:0] x);
        int n;
        n = 0;
        while (n < 32 && !x[31 - n]) begin
            n++;
        end
        return n;
    endfunction

    // expected response from the instruction rules and the current hi/lo
    function automatic exec_pkg::exec_rsp_t expected_rsp(input exec_pkg::exec_req_t req,
                                                         input logic [31:0] hi,
                                                         input logic [31:0] lo);
        exec_pkg::exec_rsp_t rsp;
        logic [31:0]         a;
        logic [31:0]         b;
        longint              s;
        longint              prod;
        a         = req.op_a;
        b         = req.op_b;
        s         = 0;
        rsp.rd    = req.rd;
        rsp.wreg  = req.wreg;
        rsp.wdata = '0;  // hi/lo writers return zero
        case (req.op)
            exec_pkg::OP_OR:   rsp.wdata = a | b;
            exec_pkg::OP_AND:  rsp.wdata = a & b;
            exec_pkg::OP_NOR:  rsp.wdata = ~(a | b);
            exec_pkg::OP_XOR:  rsp.wdata = a ^ b;
            exec_pkg::OP_SLL:  rsp.wdata = b << a[4:0];
            exec_pkg::OP_SRL:  rsp.wdata = b >> a[4:0];
            exec_pkg::OP_SRA:  rsp.wdata = $signed(b) >>> a[4:0];
            exec_pkg::OP_ADD, exec_pkg::OP_ADDU: begin
                s         = longint'($signed(a)) + longint'($signed(b));
                rsp.wdata = s[31:0];
            end
            exec_pkg::OP_SUB, exec_pkg::OP_SUBU: begin
                s         = longint'($signed(a)) - longint'($signed(b));
                rsp.wdata = s[31:0];
            end
            exec_pkg::OP_SLT:  rsp.wdata = {31'b0, $signed(a) < $signed(b)};
            exec_pkg::OP_SLTU: rsp.wdata = {31'b0, a < b};
            exec_pkg::OP_CLZ:  rsp.wdata = 32'(leading_zeros(a));
            exec_pkg::OP_CLO:  rsp.wdata = 32'(leading_zeros(~a));
            exec_pkg::OP_MUL: begin
                prod      = longint'($signed(a)) * longint'($signed(b));
                rsp.wdata = prod[31:0];
            end
            exec_pkg::OP_MFHI: rsp.wdata = hi;
            exec_pkg::OP_MFLO: rsp.wdata = lo;
            default: begin
            end
        endcase
        if ((req.op == exec_pkg::OP_ADD || req.op == exec_pkg::OP_SUB) &&
            (s > INT_MAX || s < INT_MIN)) begin
            rsp.wreg = 1'b0;  // signed result out of range
        end
        return rsp;
    endfunction

    task automatic update_hilo(input exec_pkg::exec_req_t req);
        case (req.op)
            exec_pkg::OP_MULT:  {hi_model, lo_model} = longint'($signed(req.op_a)) *
                                                       longint'($signed(req.op_b));
            exec_pkg::OP_MULTU: {hi_model, lo_model} = {32'b0, req.op_a} * {32'b0, req.op_b};
            exec_pkg::OP_MTHI:  hi_model = req.op_a;
            exec_pkg::OP_MTLO:  lo_model = req.op_a;
            default: begin
            end
        endcase
    endtask

    task automatic record_issue(input exec_pkg::exec_req_t req, input bit timed);
        exp_q.push_back(expected_rsp(req, hi_model, lo_model));
        acc_q.push_back(timed ? cycle : -1);
        update_hilo(req);  // younger instructions see this one
        n_issued++;
    endtask

    function automatic logic [31:0] pick_operand();
        logic [31:0] v;
        case (rand_below(8))
            0:       v = 32'h0000_0000;
            1:       v = 32'hFFFF_FFFF;
            2:       v = 32'h8000_0000;
            3:       v = 32'h7FFF_FFFF;
            default: v = $random(seed);
        endcase
        return v;
    endfunction

    // hi/lo traffic and add/sub weighted up
    function automatic exec_pkg::alu_op_e pick_op();
        int unsigned r;
        r = rand_below(100);
        if (r < 15) begin
            return (r % 2 == 0) ? exec_pkg::OP_MULT : exec_pkg::OP_MULTU;
        end else if (r < 30) begin
            return (r % 2 == 0) ? exec_pkg::OP_MFHI : exec_pkg::OP_MFLO;
        end else if (r < 40) begin
            return exec_pkg::alu_op_e'(exec_pkg::OP_ADD + rand_below(4));
        end else if (r < 46) begin
            return exec_pkg::alu_op_e'(exec_pkg::OP_MTHI + rand_below(2));
        end
        return exec_pkg::alu_op_e'(rand_below(22));
    endfunction

    function automatic exec_pkg::exec_req_t random_req();
        exec_pkg::exec_req_t req;
        req.op   = pick_op();
        req.op_a = pick_operand();
        req.op_b = pick_operand();
        req.rd   = exec_pkg::REG_ADDR_W'(rand_below(32));
        req.wreg = rand_below(8) != 0;
        return req;
    endfunction

    function automatic exec_pkg::exec_req_t make_req(input exec_pkg::alu_op_e op,
                                                     input logic [31:0] a,
                                                     input logic [31:0] b);
        exec_pkg::exec_req_t req;
        req.op   = op;
        req.op_a = a;
        req.op_b = b;
        req.rd   = 5'd3;
        req.wreg = 1'b1;
        return req;
    endfunction

    function automatic exec_pkg::exec_req_t next_req();
        if (directed_q.size() > 0) begin
            return directed_q.pop_front();
        end
        return random_req();
    endfunction

    task automatic issue_stream(input int count, input bit backpressure);
        int sent;
        bit taken;
        sent = 0;
        while (sent < count) begin
            @(posedge clk_i);
            taken = req_valid_i && req_ready_o;
            if (!backpressure && req_valid_i) begin
                assert (req_ready_o)
                    else fail_run("req_ready_o went low although the output was never stalled");
            end
            if (taken) begin
                record_issue(req_i, !backpressure);
                sent++;
            end
            if (backpressure) begin
                rsp_ready_i <= rand_below(100) < 70;
            end
            if (!req_valid_i || taken) begin  // otherwise hold until taken
                if (sent < count && (!backpressure || rand_below(100) < 80)) begin
                    req_valid_i <= 1'b1;
                    req_i       <= next_req();
                end else begin
                    req_valid_i <= 1'b0;
                end
            end
        end
    endtask

    initial begin
        rst_n_i     <= 1'b0;
        req_valid_i <= 1'b0;
        req_i       <= '0;
        rsp_ready_i <= 1'b0;
        directed_q.push_back(make_req(exec_pkg::OP_MFHI, 32'h0, 32'h0));  // hi/lo after reset
        directed_q.push_back(make_req(exec_pkg::OP_MFLO, 32'h0, 32'h0));
        directed_q.push_back(make_req(exec_pkg::OP_CLZ, 32'h0, 32'h0));
        directed_q.push_back(make_req(exec_pkg::OP_CLO, 32'hFFFF_FFFF, 32'h0));
        directed_q.push_back(make_req(exec_pkg::OP_SRA, 32'd4, 32'h8000_0010));
        directed_q.push_back(make_req(exec_pkg::OP_ADD, 32'h7FFF_FFFF, 32'h1));
        directed_q.push_back(make_req(exec_pkg::OP_ADDU, 32'h7FFF_FFFF, 32'h1));
        directed_q.push_back(make_req(exec_pkg::OP_SUB, 32'h8000_0000, 32'h1));
        directed_q.push_back(make_req(exec_pkg::OP_SUBU, 32'h8000_0000, 32'h1));
        directed_q.push_back(make_req(exec_pkg::OP_SLT, 32'h8000_0000, 32'h1));
        directed_q.push_back(make_req(exec_pkg::OP_SLTU, 32'h8000_0000, 32'h1));
        directed_q.push_back(make_req(exec_pkg::OP_MULT, 32'h8000_0000, 32'h3));
        directed_q.push_back(make_req(exec_pkg::OP_MFHI, 32'h0, 32'h0));
        directed_q.push_back(make_req(exec_pkg::OP_MFLO, 32'h0, 32'h0));
        directed_q.push_back(make_req(exec_pkg::OP_MULTU, 32'h8000_0000, 32'h3));
        directed_q.push_back(make_req(exec_pkg::OP_MFHI, 32'h0, 32'h0));
        directed_q.push_back(make_req(exec_pkg::OP_MTHI, 32'h1234_5678, 32'h0));
        directed_q.push_back(make_req(exec_pkg::OP_MFLO, 32'h0, 32'h0));
        directed_q.push_back(make_req(exec_pkg::OP_MFHI, 32'h0, 32'h0));
        directed_q.push_back(make_req(exec_pkg::OP_MTLO, 32'h0F0F_1234, 32'h0));
        directed_q.push_back(make_req(exec_pkg::OP_MFHI, 32'h0, 32'h0));
        directed_q.push_back(make_req(exec_pkg::OP_MFLO, 32'h0, 32'h0));
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i     <= 1'b1;
        rsp_ready_i <= 1'b1;
        issue_stream(STEADY_TXN, 1'b0);
        wait (n_checked == n_issued);  // drain before back-pressure starts
        issue_stream(NUM_TXN - STEADY_TXN, 1'b1);
        rsp_ready_i <= 1'b1;  // let the tail of the stream drain
        wait (n_checked == NUM_TXN);
        repeat (4) @(posedge clk_i);
        if (!rsp_valid_o) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            fail_run("a response appeared after the last expected one");
        end
    end

    // one check per output transfer
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            assert (!rsp_valid_o) else fail_run("rsp_valid_o was high during reset");
        end else begin
            if (held_valid) begin
                assert (rsp_valid_o)
                    else fail_run("rsp_valid_o dropped before a stalled response was taken");
                assert (rsp_o == held_rsp)
                    else value_error("rsp_o (stalled)", 64'(held_rsp), 64'(rsp_o));
            end
            if (rsp_valid_o && rsp_ready_i) begin
                assert (exp_q.size() > 0)
                    else fail_run("a response came out with no instruction outstanding");
                exp_rsp   = exp_q.pop_front();
                acc_cycle = acc_q.pop_front();
                assert (rsp_o == exp_rsp)
                    else value_error("rsp_o", 64'(exp_rsp), 64'(rsp_o));
                if (acc_cycle >= 0) begin
                    assert (cycle - acc_cycle == LATENCY)
                        else value_error("latency", 64'(LATENCY), 64'(cycle - acc_cycle));
                end
                n_checked++;
            end
            held_valid = rsp_valid_o && !rsp_ready_i;
            held_rsp   = rsp_o;
        end
    end

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout: only %0d of %0d responses arrived within %0d cycles",
                               n_checked, NUM_TXN, TIMEOUT_CYCLES));
        end
    end

endmodule

//--- flist.f
common/exec_pkg.sv
alu/exec_alu.sv
mult/exec_multiplier.sv
design/operand_stage.sv
design/compute_stage.sv
design/writeback_stage.sv
design/exec_unit_top.sv
sim/exec_unit_tb.sv

//--- Makefile
# Verilator flow for the execute unit

TB_TOP  := exec_unit_tb
RTL_TOP := exec_unit_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module $(RTL_TOP)
	verilator --lint-only --timing --assert -f flist.f --top-module $(TB_TOP)

sim:
	verilator --binary --assert -j 0 -f flist.f --top-module $(TB_TOP) -o $(TB_TOP)
	./obj_dir/$(TB_TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
